// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= operand_unit_tb
FILELIST  ?= operand_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Simulation PASSED

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   list the targets"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== operand_unit.f ====
src/operand_pkg.sv
src/register_memory.sv
src/bus_arbiter.sv
src/register_manager.sv
src/operand_sequencer.sv
src/operand_unit_top.sv
testbench/operand_unit_tb.sv

// ==== src/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  wire                    clk,
  input  wire                    rst,
  input  operand_pkg::bus_req_t  host_req,
  input  operand_pkg::bus_req_t  src_req,
  input  operand_pkg::bus_req_t  dst_req,
  output operand_pkg::bus_req_t  mem_req,
  input  operand_pkg::bus_rsp_t  mem_rsp,
  output operand_pkg::bus_rsp_t  host_rsp,
  output operand_pkg::bus_rsp_t  src_rsp,
  output operand_pkg::bus_rsp_t  dst_rsp,
  output logic                   src_grant,
  output logic                   dst_grant
);

  typedef enum logic [1:0] {
    own_host,
    own_src,
    own_dst
  } owner_t;

  owner_t owner_q;
  logic   pending_q;
  logic   host_act;
  logic   src_act;
  logic   dst_act;
  logic   rsp_dn;

  assign host_act = host_req.rd | host_req.wr;
  assign src_act  = src_req.rd | src_req.wr;
  assign dst_act  = dst_req.rd | dst_req.wr;
  assign rsp_dn   = mem_rsp.read_dn | mem_rsp.write_dn;

  // fixed priority while the bus is free
  assign src_grant = !pending_q && !host_act;
  assign dst_grant = !pending_q && !host_act && !src_act;

  always_comb begin
    mem_req = '0;
    if (!pending_q) begin
      if (host_act) begin
        mem_req = host_req;
      end else if (src_act) begin
        mem_req = src_req;
      end else if (dst_act) begin
        mem_req = dst_req;
      end
    end
  end

  // owner held until its done pulse comes back
  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= 1'b0;
      owner_q   <= own_host;
    end else if (pending_q) begin
      if (rsp_dn) begin
        pending_q <= 1'b0;
      end
    end else if (mem_req.rd || mem_req.wr) begin
      pending_q <= 1'b1;
      owner_q   <= host_act ? own_host : (src_act ? own_src : own_dst);
    end
  end

  // response goes to the grant owner only
  assign host_rsp = (pending_q && owner_q == own_host) ? mem_rsp : '0;
  assign src_rsp  = (pending_q && owner_q == own_src) ? mem_rsp : '0;
  assign dst_rsp  = (pending_q && owner_q == own_dst) ? mem_rsp : '0;

endmodule

`default_nettype wire

// ==== src/operand_pkg.sv ====
`default_nettype none

package operand_pkg;

  // memory geometry
  localparam int addr_w = 8;
  localparam int data_w = 32;
  localparam int mem_words = 256;

  // register 15 doubles as the instruction pointer
  localparam logic [3:0] ip_reg = 4'd15;

  // operand adjust flags
  localparam logic [1:0] flag_inc = 2'b01;
  localparam logic [1:0] flag_dec = 2'b10;

  // operation codes driven by the sequencer to each manager
  typedef enum logic [2:0] {
    op_idle,
    op_preexecute,
    op_read,
    op_read_p,
    op_load_result,
    op_write_prep,
    op_write,
    op_finish
  } reg_op_t;

  // one operand of a command
  typedef struct packed {
    logic [3:0] reg_num;
    logic       is_ptr;
    logic [1:0] flags;
    logic       need_save;
  } operand_spec_t;

  // move command with src ahead of dst
  typedef struct packed {
    operand_spec_t src;
    operand_spec_t dst;
  } command_t;

  // single request to the register memory
  typedef struct packed {
    logic              rd;
    logic              wr;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } bus_req_t;

  // response one cycle after the request
  typedef struct packed {
    logic              read_dn;
    logic              write_dn;
    logic [data_w-1:0] rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

// ==== src/operand_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_sequencer (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          cmd_valid,
  input  operand_pkg::command_t        cmd,
  output operand_pkg::operand_spec_t   src_spec,
  output operand_pkg::operand_spec_t   dst_spec,
  output operand_pkg::reg_op_t         src_op,
  output operand_pkg::reg_op_t         dst_op,
  input  wire                          src_step_done,
  input  wire                          dst_step_done,
  output logic                         busy,
  output logic                         done
);

  typedef enum logic [3:0] {
    s_idle,
    s_pre,
    s_read,
    s_read_p,
    s_load,
    s_dst_write,
    s_prep,
    s_src_write,
    s_finish
  } seq_state_t;

  seq_state_t            state;
  operand_pkg::command_t cmd_q;
  logic                  src_adjust;

  // write back only for inc or dec
  assign src_adjust = (cmd_q.src.flags == operand_pkg::flag_inc) ||
                      (cmd_q.src.flags == operand_pkg::flag_dec);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= s_idle;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        s_idle:      if (cmd_valid) state <= s_pre;
        // both managers finish preexecute together
        s_pre:       if (src_step_done && dst_step_done) state <= s_read;
        s_read:      if (src_step_done) state <= cmd_q.src.is_ptr ? s_read_p : s_load;
        s_read_p:    if (src_step_done) state <= s_load;
        s_load:      if (dst_step_done) state <= s_dst_write;
        s_dst_write: if (dst_step_done) state <= src_adjust ? s_prep : s_finish;
        s_prep:      if (src_step_done) state <= s_src_write;
        s_src_write: if (src_step_done) state <= s_finish;
        s_finish: begin
          if (src_step_done && dst_step_done) begin
            state <= s_idle;
            done  <= 1'b1;
          end
        end
        default:     state <= s_idle;
      endcase
    end
  end

  // command held for the whole move
  always_ff @(posedge clk) begin
    if (state == s_idle && cmd_valid) begin
      cmd_q <= cmd;
    end
  end

  always_comb begin
    src_op = operand_pkg::op_idle;
    dst_op = operand_pkg::op_idle;
    case (state)
      s_pre:       begin
        src_op = operand_pkg::op_preexecute;
        dst_op = operand_pkg::op_preexecute;
      end
      s_read:      src_op = operand_pkg::op_read;
      s_read_p:    src_op = operand_pkg::op_read_p;
      s_load:      dst_op = operand_pkg::op_load_result;
      s_dst_write: dst_op = operand_pkg::op_write;
      s_prep:      src_op = operand_pkg::op_write_prep;
      s_src_write: src_op = operand_pkg::op_write;
      s_finish:    begin
        src_op = operand_pkg::op_finish;
        dst_op = operand_pkg::op_finish;
      end
      default:     begin
      end
    endcase
  end

  // dst is always stored, so it always owes a save
  always_comb begin
    src_spec           = cmd_q.src;
    dst_spec           = cmd_q.dst;
    dst_spec.need_save = 1'b1;
  end

  assign busy = state != s_idle;

endmodule

`default_nettype wire

// ==== src/operand_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_unit_top (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            cmd_valid,
  input  operand_pkg::command_t          cmd,
  input  wire [operand_pkg::data_w-1:0]  cmd_ptr,
  output logic                           busy,
  output logic                           done,
  input  operand_pkg::bus_req_t          host_req,
  output operand_pkg::bus_rsp_t          host_rsp
);

  operand_pkg::operand_spec_t     src_spec;
  operand_pkg::operand_spec_t     dst_spec;
  operand_pkg::reg_op_t           src_op;
  operand_pkg::reg_op_t           dst_op;
  logic                           src_step_done;
  logic                           dst_step_done;
  operand_pkg::bus_req_t          src_req;
  operand_pkg::bus_req_t          dst_req;
  operand_pkg::bus_rsp_t          src_rsp;
  operand_pkg::bus_rsp_t          dst_rsp;
  logic                           src_grant;
  logic                           dst_grant;
  logic [operand_pkg::data_w-1:0] src_value;
  operand_pkg::bus_req_t          host_req_idle;
  operand_pkg::bus_req_t          mem_req;
  operand_pkg::bus_rsp_t          mem_rsp;

  // host port dropped while a command runs
  assign host_req_idle = busy ? '0 : host_req;

  operand_sequencer seq_i (
    .clk, .rst, .cmd_valid, .cmd, .src_spec, .dst_spec, .src_op, .dst_op,
    .src_step_done, .dst_step_done, .busy, .done
  );

  // src reads and adjusts, dst stores the moved word
  register_manager src_mgr_i (
    .clk, .rst, .op(src_op), .spec(src_spec), .cmd_ptr, .load_value('0),
    .grant(src_grant), .req(src_req), .rsp(src_rsp), .value(src_value),
    .step_done(src_step_done)
  );

  register_manager dst_mgr_i (
    .clk, .rst, .op(dst_op), .spec(dst_spec), .cmd_ptr, .load_value(src_value),
    .grant(dst_grant), .req(dst_req), .rsp(dst_rsp), .value(),
    .step_done(dst_step_done)
  );

  bus_arbiter arb_i (
    .clk, .rst, .host_req(host_req_idle), .src_req, .dst_req, .mem_req, .mem_rsp,
    .host_rsp, .src_rsp, .dst_rsp, .src_grant, .dst_grant
  );

  register_memory mem_i (
    .clk, .rst, .req(mem_req), .rsp(mem_rsp)
  );

endmodule

`default_nettype wire

// ==== src/register_manager.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_manager (
  input  wire                               clk,
  input  wire                               rst,
  input  operand_pkg::reg_op_t              op,
  input  operand_pkg::operand_spec_t        spec,
  input  wire [operand_pkg::data_w-1:0]     cmd_ptr,
  input  wire [operand_pkg::data_w-1:0]     load_value,
  input  wire                               grant,
  output operand_pkg::bus_req_t             req,
  input  operand_pkg::bus_rsp_t             rsp,
  output logic [operand_pkg::data_w-1:0]    value,
  output logic                              step_done
);

  // latched operand state
  logic [3:0]                     reg_num_q;
  logic [operand_pkg::data_w-1:0] addr_q;
  logic [operand_pkg::data_w-1:0] value_q;
  logic [operand_pkg::addr_w-1:0] pend_addr_q;
  logic                           save_pending;
  // one bus request per operation
  logic                           issued;

  logic                           is_read;
  logic                           is_ip;
  logic                           want_bus;
  logic                           bus_issue;
  logic [operand_pkg::addr_w-1:0] req_addr;
  logic [operand_pkg::addr_w-1:0] expect_addr;
  logic                           rd_accept;
  logic                           wr_accept;

  assign is_read = (op == operand_pkg::op_read) || (op == operand_pkg::op_read_p);

  // ip register answers from cmd_ptr without a bus cycle
  always_comb begin
    if (op == operand_pkg::op_read_p) begin
      is_ip = value_q == {{(operand_pkg::data_w-4){1'b0}}, operand_pkg::ip_reg};
    end else begin
      is_ip = addr_q == {{(operand_pkg::data_w-4){1'b0}}, operand_pkg::ip_reg};
    end
  end

  // address put on the bus for this operation
  always_comb begin
    req_addr    = addr_q[operand_pkg::addr_w-1:0];
    expect_addr = addr_q[operand_pkg::addr_w-1:0];
    if (op == operand_pkg::op_read_p) begin
      // in the pointer case the register value is the address
      req_addr = value_q[operand_pkg::addr_w-1:0];
    end else if (op == operand_pkg::op_write) begin
      req_addr    = {{(operand_pkg::addr_w-4){1'b0}}, reg_num_q};
      expect_addr = {{(operand_pkg::addr_w-4){1'b0}}, reg_num_q};
    end
  end

  // write only when a save is owed
  assign want_bus = (is_read && !is_ip) || (op == operand_pkg::op_write && save_pending);
  assign bus_issue = want_bus && !issued && !step_done && grant;

  // only the response to our own address counts
  assign rd_accept = issued && rsp.read_dn && (pend_addr_q == expect_addr);
  assign wr_accept = issued && rsp.write_dn && (pend_addr_q == expect_addr);

  always_comb begin
    req       = '0;
    req.rd    = bus_issue && is_read;
    req.wr    = bus_issue && (op == operand_pkg::op_write);
    req.addr  = req_addr;
    req.wdata = value_q;
  end

  // control flow per operation
  always_ff @(posedge clk) begin
    if (rst) begin
      step_done    <= 1'b0;
      issued       <= 1'b0;
      save_pending <= 1'b0;
    end else if (step_done) begin
      // op still shows the old code this cycle
      step_done <= 1'b0;
      issued    <= 1'b0;
    end else begin
      case (op)
        operand_pkg::op_preexecute: begin
          // odd parity means inc or dec
          save_pending <= (^spec.flags) | spec.need_save;
          step_done    <= 1'b1;
        end
        operand_pkg::op_read, operand_pkg::op_read_p: begin
          if (is_ip) begin
            step_done <= 1'b1;
          end else if (bus_issue) begin
            issued <= 1'b1;
          end else if (rd_accept) begin
            step_done <= 1'b1;
          end
        end
        operand_pkg::op_load_result, operand_pkg::op_write_prep: begin
          step_done <= 1'b1;
        end
        operand_pkg::op_write: begin
          if (!save_pending) begin
            step_done <= 1'b1;
          end else if (bus_issue) begin
            issued <= 1'b1;
          end else if (wr_accept) begin
            save_pending <= 1'b0;
            step_done    <= 1'b1;
          end
        end
        operand_pkg::op_finish: begin
          save_pending <= 1'b0;
          step_done    <= 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  // operand data path
  always_ff @(posedge clk) begin
    if (!step_done) begin
      case (op)
        operand_pkg::op_preexecute: begin
          reg_num_q <= spec.reg_num;
          addr_q    <= {{(operand_pkg::data_w-4){1'b0}}, spec.reg_num};
        end
        operand_pkg::op_read: begin
          if (is_ip) begin
            value_q <= cmd_ptr;
          end else if (rd_accept) begin
            value_q <= rsp.rdata;
          end
        end
        operand_pkg::op_read_p: begin
          // keep the full pointer for a later adjust
          if (is_ip || bus_issue) begin
            addr_q <= value_q;
          end
          if (is_ip) begin
            value_q <= cmd_ptr;
          end else if (rd_accept) begin
            value_q <= rsp.rdata;
          end
        end
        operand_pkg::op_load_result: begin
          value_q <= load_value;
        end
        operand_pkg::op_write_prep: begin
          if (spec.flags == operand_pkg::flag_inc) begin
            value_q <= (spec.is_ptr ? addr_q : value_q) + 1'b1;
          end else if (spec.flags == operand_pkg::flag_dec) begin
            value_q <= (spec.is_ptr ? addr_q : value_q) - 1'b1;
          end
        end
        default: begin
        end
      endcase
      if (bus_issue) begin
        pend_addr_q <= req_addr;
      end
    end
  end

  assign value = value_q;

endmodule

`default_nettype wire

// ==== src/register_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_memory (
  input  wire                    clk,
  input  wire                    rst,
  input  operand_pkg::bus_req_t  req,
  output operand_pkg::bus_rsp_t  rsp
);

  // word storage with registers 0..15 at the bottom
  logic [operand_pkg::data_w-1:0] mem [operand_pkg::mem_words];

  logic                           read_dn_q;
  logic                           write_dn_q;
  logic [operand_pkg::data_w-1:0] rdata_q;

  // done pulses one cycle after the request
  always_ff @(posedge clk) begin
    if (rst) begin
      read_dn_q  <= 1'b0;
      write_dn_q <= 1'b0;
    end else begin
      read_dn_q  <= req.rd;
      write_dn_q <= req.wr;
    end
  end

  // array and read data
  always_ff @(posedge clk) begin
    if (req.wr) begin
      mem[req.addr] <= req.wdata;
    end
    // read data held until the next read
    if (req.rd) begin
      rdata_q <= mem[req.addr];
    end
  end

  always_comb begin
    rsp          = '0;
    rsp.read_dn  = read_dn_q;
    rsp.write_dn = write_dn_q;
    rsp.rdata    = rdata_q;
  end

endmodule

`default_nettype wire

// ==== testbench/operand_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_unit_tb;

  localparam int timeout_cycles = 200;

  logic                           clk;
  logic                           rst;
  logic                           cmd_valid;
  operand_pkg::command_t          cmd;
  logic [operand_pkg::data_w-1:0] cmd_ptr;
  logic                           busy;
  logic                           done;
  operand_pkg::bus_req_t          host_req;
  operand_pkg::bus_rsp_t          host_rsp;

  // expected memory contents
  logic [operand_pkg::data_w-1:0] model [operand_pkg::mem_words];

  int errors = 0;
  int checks = 0;
  int tests = 0;
  int done_pulses = 0;
  int ip_reads = 0;

  operand_unit_top dut_i (
    .clk, .rst, .cmd_valid, .cmd, .cmd_ptr, .busy, .done, .host_req, .host_rsp
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // sampled mid cycle away from the edges
  always @(negedge clk) begin
    if (!rst && done) done_pulses++;
    if (dut_i.mem_req.rd && dut_i.mem_req.addr == 8'd15) ip_reads++;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("mismatch %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic finish_test(input string name, input int start_errors);
    tests++;
    $display("test %s finished, %0d errors", name, errors - start_errors);
  endtask

  // one host request, then wait for its own done pulse
  task automatic host_access(input logic is_read, input logic [7:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    operand_pkg::bus_req_t r;
    int n;
    logic got;
    r = '0;
    r.rd = is_read;
    r.wr = !is_read;
    r.addr = addr;
    r.wdata = wdata;
    @(posedge clk);
    host_req <= r;
    @(posedge clk);
    host_req <= '0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      got = is_read ? host_rsp.read_dn : host_rsp.write_dn;
    end while (!got && n < timeout_cycles);
    rdata = host_rsp.rdata;
    if (!got) begin
      errors++;
      $display("memory gave no response to a host access at address %h", addr);
    end
  endtask

  task automatic load_word(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    host_access(1'b0, addr, data, unused);
    model[addr] = data;
  endtask

  task automatic expect_word(input string name, input logic [7:0] addr);
    logic [31:0] rdata;
    host_access(1'b1, addr, '0, rdata);
    check_value(name, model[addr], rdata);
  endtask

  function automatic operand_pkg::operand_spec_t make_spec(input logic [3:0] num,
      input logic is_ptr, input logic [1:0] flags);
    operand_pkg::operand_spec_t s;
    s.reg_num = num;
    s.is_ptr = is_ptr;
    s.flags = flags;
    s.need_save = 1'b0;
    return s;
  endfunction

  // ip reads cmd_ptr and dst is stored before the src adjust
  task automatic update_model(input operand_pkg::command_t c, input logic [31:0] ptr);
    logic [31:0] src_val;
    logic [31:0] data;
    logic [31:0] adj;
    src_val = (c.src.reg_num == 4'd15) ? ptr : model[c.src.reg_num];
    data = c.src.is_ptr ? model[src_val[7:0]] : src_val;
    model[c.dst.reg_num] = data;
    adj = c.src.is_ptr ? src_val : data;
    if (c.src.flags == 2'b01) model[c.src.reg_num] = adj + 32'd1;
    if (c.src.flags == 2'b10) model[c.src.reg_num] = adj - 32'd1;
  endtask

  task automatic run_move(input string name, input operand_pkg::operand_spec_t src,
                          input operand_pkg::operand_spec_t dst, input logic [31:0] ptr);
    operand_pkg::command_t c;
    int n;
    int pulses_before;
    c.src = src;
    c.dst = dst;
    pulses_before = done_pulses;
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd <= c;
    cmd_ptr <= ptr;
    @(posedge clk);
    cmd_valid <= 1'b0;
    @(negedge clk);
    check_value({name, " busy"}, 32'd1, {31'd0, busy});
    n = 0;
    while (!done && n < timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (!done) begin
      errors++;
      $display("command in test %s never signalled done", name);
    end
    repeat (2) @(negedge clk);
    check_value({name, " done pulses"}, 32'd1, done_pulses - pulses_before);
    check_value({name, " idle"}, 32'd0, {31'd0, busy});
    update_model(c, ptr);
  endtask

  task automatic reset_state();
    int start;
    start = errors;
    check_value("reset busy", 32'd0, {31'd0, busy});
    check_value("reset done", 32'd0, {31'd0, done});
    finish_test("reset_state", start);
  endtask

  task automatic direct_move();
    int start;
    start = errors;
    load_word(8'd1, $urandom);
    load_word(8'd2, $urandom);
    run_move("direct", make_spec(4'd1, 1'b0, 2'b00), make_spec(4'd2, 1'b0, 2'b00), '0);
    expect_word("direct reg2", 8'd2);
    expect_word("direct reg1", 8'd1);
    finish_test("direct_move", start);
  endtask

  task automatic pointer_read();
    int start;
    logic [7:0] ptr;
    start = errors;
    ptr = 8'(32 + $urandom % 200);
    load_word(8'd3, {24'd0, ptr});
    load_word(ptr, $urandom);
    run_move("pointer", make_spec(4'd3, 1'b1, 2'b00), make_spec(4'd4, 1'b0, 2'b00), '0);
    expect_word("pointer reg4", 8'd4);
    expect_word("pointer reg3", 8'd3);
    finish_test("pointer_read", start);
  endtask

  // post-increment, post-decrement, then a plain increment
  task automatic adjust_write_back();
    int start;
    logic [7:0] ptr;
    start = errors;
    ptr = 8'(32 + $urandom % 200);
    load_word(8'd3, {24'd0, ptr});
    load_word(ptr, $urandom);
    run_move("inc ptr", make_spec(4'd3, 1'b1, 2'b01), make_spec(4'd4, 1'b0, 2'b00), '0);
    expect_word("inc ptr reg4", 8'd4);
    expect_word("inc ptr reg3", 8'd3);
    load_word(8'd3, {24'd0, ptr});
    run_move("dec ptr", make_spec(4'd3, 1'b1, 2'b10), make_spec(4'd4, 1'b0, 2'b00), '0);
    expect_word("dec ptr reg4", 8'd4);
    expect_word("dec ptr reg3", 8'd3);
    load_word(8'd5, $urandom);
    run_move("inc value", make_spec(4'd5, 1'b0, 2'b01), make_spec(4'd6, 1'b0, 2'b00), '0);
    expect_word("inc value reg6", 8'd6);
    expect_word("inc value reg5", 8'd5);
    finish_test("adjust", start);
  endtask

  task automatic instruction_pointer();
    int start;
    int reads_before;
    logic [31:0] ip;
    start = errors;
    ip = $urandom;
    // word 15 differs so a memory read would show
    load_word(8'd15, ~ip);
    reads_before = ip_reads;
    run_move("ip", make_spec(4'd15, 1'b0, 2'b00), make_spec(4'd7, 1'b0, 2'b00), ip);
    check_value("ip word 15 reads", 32'd0, ip_reads - reads_before);
    expect_word("ip reg7", 8'd7);
    expect_word("ip word 15", 8'd15);
    finish_test("instruction_pointer", start);
  endtask

  // back-to-back commands with host reads in between
  task automatic back_to_back();
    int start;
    logic [3:0] src;
    logic [3:0] dst;
    logic [1:0] flags;
    start = errors;
    check_value("idle busy", 32'd0, {31'd0, busy});
    for (int i = 0; i < 4; i++) begin
      src = 4'(8 + $urandom % 3);
      dst = 4'(11 + $urandom % 4);
      flags = 2'($urandom % 3);
      run_move("back to back", make_spec(src, 1'b0, flags), make_spec(dst, 1'b0, 2'b00), '0);
      for (int r = 0; r < 16; r++) begin
        expect_word("back to back regs", 8'(r));
      end
    end
    finish_test("back_to_back", start);
  endtask

  initial begin
    void'($urandom(78763));
    rst = 1'b1;
    cmd_valid = 1'b0;
    cmd = '0;
    cmd_ptr = '0;
    host_req = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    reset_state();
    // registers start from random words
    for (int i = 0; i < 16; i++) begin
      load_word(8'(i), $urandom);
    end
    direct_move();
    pointer_read();
    adjust_write_back();
    instruction_pointer();
    back_to_back();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
